//--- Makefile
# Verilator simulation of the bar-chart renderer.

SIM := obj_dir/Vtb_plot_renderer

.PHONY: all run clean

all: run

$(SIM): vlog.f verilog/*.sv verification/*.sv
	verilator --binary --timing --assert -Wno-fatal --top-module tb_plot_renderer -f vlog.f

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- verification/plot_trace.txt
# op value(s) expected_newest_height, decimal
# S v h sends one sample, B v1 v2 h sends two samples during a running frame
S 5 5
S 12 12
S 32 32
S 40 32
S 0 0
S 1 1
S 3 3
B 7 9 9
S 31 31
S 65535 32
S 16 16
S 2 2
S 4 4
S 8 8
S 33 32
S 20 20
S 6 6
B 100 11 11
S 27 27
S 13 13

//--- verification/sdram_burst_model.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_burst_model
    import plot_map_pkg::*;
(
    input  wire                clk,
    input  wire                rst_n,
    input  wire                rd_req,
    input  wire  [ADDR_W-1:0]  rd_addr,
    output logic [BURST_W-1:0] rd_data,
    output logic               rd_done,
    input  wire                wr_req,
    input  wire  [ADDR_W-1:0]  wr_addr,
    input  wire  [BURST_W-1:0] wr_data,
    output logic               wr_done
);

    logic [WORD_W-1:0] store [logic [ADDR_W-1:0]]; // Only written words exist.
    logic              rd_busy;
    logic              wr_busy;
    int unsigned       rd_wait;                    // Cycles left to done.
    int unsigned       wr_wait;

    initial begin
        void'($urandom(32'h6855)); // One seed for the whole run.
    end

    // Unwritten words read back a pattern of their own address.
    function automatic logic [WORD_W-1:0] peek(input logic [ADDR_W-1:0] addr);
        if (store.exists(addr)) begin
            return store[addr];
        end
        return addr[15:0] ^ {8'h00, addr[23:16]} ^ 16'h5A5A;
    endfunction

    ////////////////////////////////////////
    // Read port.
    ////////////////////////////////////////
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_busy <= 1'b0;
            rd_wait <= 0;
            rd_done <= 1'b0;
            rd_data <= '0;
        end else begin
            rd_done <= 1'b0;
            if (rd_busy) begin
                if (rd_wait <= 1) begin
                    for (int i = 0; i < BURST_LEN; i++) begin
                        rd_data[i*WORD_W +: WORD_W] <= peek(rd_addr + ADDR_W'(i));
                    end
                    rd_done <= 1'b1; // Data and done in the same cycle.
                    rd_busy <= 1'b0;
                end else begin
                    rd_wait <= rd_wait - 1;
                end
            end else if (rd_req && !rd_done) begin
                // Req still high in the done cycle, no restart.
                rd_busy <= 1'b1;
                rd_wait <= $urandom_range(8, 1);
            end
        end
    end

    ////////////////////////////////////////
    // Write port.
    ////////////////////////////////////////
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_busy <= 1'b0;
            wr_wait <= 0;
            wr_done <= 1'b0;
        end else begin
            wr_done <= 1'b0;
            if (wr_busy) begin
                if (wr_wait <= 1) begin
                    for (int i = 0; i < BURST_LEN; i++) begin
                        store[wr_addr + ADDR_W'(i)] = wr_data[i*WORD_W +: WORD_W];
                    end
                    wr_done <= 1'b1;
                    wr_busy <= 1'b0;
                end else begin
                    wr_wait <= wr_wait - 1;
                end
            end else if (wr_req && !wr_done) begin
                wr_busy <= 1'b1;
                wr_wait <= $urandom_range(8, 1); // Latency 1 to 8.
            end
        end
    end

endmodule

`default_nettype wire

//--- verification/tb_plot_renderer.sv
`timescale 1ns/1ps
`default_nettype none

module tb_plot_renderer
    import plot_map_pkg::*;
    import pixel_pkg::*;
();

    localparam int                PLOT_COLS   = 16;
    localparam int                PLOT_HEIGHT = 32;
    localparam int                LINE_STRIDE = 64;
    localparam logic [ADDR_W-1:0] PLOT_ORIGIN = 24'h00_0040;

    logic               clk;
    logic               rst_n;
    logic               sample_valid;
    logic [WORD_W-1:0]  sample_value;
    logic               rd_req;
    logic [ADDR_W-1:0]  rd_addr;
    logic [BURST_W-1:0] rd_data;
    logic               rd_done;
    logic               wr_req;
    logic [ADDR_W-1:0]  wr_addr;
    logic [BURST_W-1:0] wr_data;
    logic               wr_done;
    logic               busy;
    logic               frame_done;

    // Trace commands.
    byte   cmd_op[$];
    int    cmd_v1[$];
    int    cmd_v2[$];
    int    cmd_h[$];
    int    trace_lines = 0;

    int    hist[$];            // Samples taken by a frame, oldest first.
    int    cycles      = 0;
    int    cycle_limit = 0;    // Zero until the trace is read.
    int    test_errors = 0;
    int    total_errors = 0;
    int    tests_run   = 0;
    int    tests_failed = 0;
    bit    in_flight   = 1'b0; // Frame running, not yet checked.
    int    flight_h;
    string flight_name;

    plot_renderer_top #(
        .PLOT_COLS   (PLOT_COLS),
        .PLOT_HEIGHT (PLOT_HEIGHT),
        .LINE_STRIDE (LINE_STRIDE),
        .PLOT_ORIGIN (PLOT_ORIGIN)
    ) uut (
        .clk, .rst_n, .sample_valid, .sample_value,
        .rd_req, .rd_addr, .rd_data, .rd_done,
        .wr_req, .wr_addr, .wr_data, .wr_done,
        .busy, .frame_done
    );

    sdram_burst_model mem (
        .clk, .rst_n,
        .rd_req, .rd_addr, .rd_data, .rd_done,
        .wr_req, .wr_addr, .wr_data, .wr_done
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk; // 20 ns period.
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d clock cycles.", cycle_limit);
            $display("TESTS FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Stimulus helpers.
    ////////////////////////////////////////
    task automatic next_cycle();
        @(posedge clk);
        #2; // Drive and sample clear of the edge.
    endtask

    task automatic strobe_sample(input int value);
        sample_valid = 1'b1;
        sample_value = WORD_W'(value);
        next_cycle();
        sample_valid = 1'b0;
    endtask

    task automatic wait_busy(input logic level);
        while (busy !== level) begin
            next_cycle();
        end
    endtask

    task automatic wait_frame_done();
        while (frame_done !== 1'b1) begin
            next_cycle();
        end
    endtask

    ////////////////////////////////////////
    // Expected memory image.
    ////////////////////////////////////////
    function automatic logic [ADDR_W-1:0] pixel_addr(input int col, input int pix);
        return PLOT_ORIGIN + ADDR_W'(col * LINE_STRIDE + pix);
    endfunction

    function automatic logic [ADDR_W-1:0] slot_word_addr(input int slot, input int word);
        return RING_BASE + ADDR_W'(BURST_LEN * slot + word);
    endfunction

    function automatic int clip(input int value);
        return (value > PLOT_HEIGHT) ? PLOT_HEIGHT : value;
    endfunction

    // Column c holds the c-th oldest of the last PLOT_COLS samples.
    function automatic int expected_height(input int col);
        int idx;
        idx = hist.size() - PLOT_COLS + col;
        if (idx < 0) begin
            return 0; // Slot still holds its init zero.
        end
        return clip(hist[idx]);
    endfunction

    function automatic int measure_bar(input int col);
        int n;
        n = 0;
        while (n < PLOT_HEIGHT && mem.peek(pixel_addr(col, n)) == COLOR_BAR) begin
            n++;
        end
        return n;
    endfunction

    task automatic check_word(input logic [ADDR_W-1:0] addr, input logic [15:0] exp,
                              input string what);
        logic [15:0] got;
        got = mem.peek(addr);
        assert (got == exp) else begin
            $display("FAIL @%0t: %s at %h reads %h, expected %h", $time, what, addr, got, exp);
            test_errors++;
        end
    endtask

    task automatic check_idle_ports(input string where);
        assert (rd_req === 1'b0 && wr_req === 1'b0 && frame_done === 1'b0) else begin
            $display("FAIL @%0t: request or frame_done high %s", $time, where);
            test_errors++;
        end
    endtask

    task automatic check_init();
        for (int s = 0; s < PLOT_COLS; s++) begin
            for (int w = 0; w < BURST_LEN; w++) begin
                check_word(slot_word_addr(s, w), 16'h0000,
                           $sformatf("ring slot %0d word %0d", s, w));
            end
        end
        for (int c = 0; c < PLOT_COLS; c++) begin
            for (int p = 0; p < PLOT_HEIGHT; p++) begin
                check_word(pixel_addr(c, p), COLOR_CLEAR,
                           $sformatf("cleared column %0d pixel %0d", c, p));
            end
        end
    endtask

    task automatic check_plot(input int h);
        int eh;
        int got_h;
        for (int c = 0; c < PLOT_COLS; c++) begin
            eh = expected_height(c);
            for (int p = 0; p < PLOT_HEIGHT; p++) begin
                check_word(pixel_addr(c, p), (p < eh) ? COLOR_BAR : COLOR_BACKGROUND,
                           $sformatf("column %0d pixel %0d", c, p));
            end
        end
        got_h = measure_bar(PLOT_COLS - 1); // Newest column.
        assert (got_h == h) else begin
            $display("FAIL @%0t: newest bar is %0d high, trace expects %0d", $time, got_h, h);
            test_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            $display("test %0d %s: %0d errors", tests_run, name, test_errors);
            tests_failed++;
        end
        total_errors += test_errors;
        test_errors = 0;
    endtask

    ////////////////////////////////////////
    // Trace commands.
    ////////////////////////////////////////
    task automatic complete_frame();
        wait_frame_done();
        check_plot(flight_h);
        finish_test(flight_name);
        in_flight = 1'b0;
    endtask

    // Frame check is left open, so a pair can overlap this frame.
    task automatic run_single(input int v, input int h, input string name);
        if (in_flight) begin
            complete_frame();
        end
        strobe_sample(v);
        wait_busy(1'b1);
        hist.push_back(v);
        in_flight   = 1'b1;
        flight_h    = h;
        flight_name = name;
    endtask

    task automatic run_pair(input int v1, input int v2, input int h, input string name);
        int  pair_errors;
        bit  extra;
        assert (busy) else begin
            $display("FAIL @%0t: busy low when the first sample of the pair was sent", $time);
            test_errors++;
        end
        strobe_sample(v1);
        next_cycle();
        assert (busy) else begin
            $display("FAIL @%0t: busy low when the second sample of the pair was sent", $time);
            test_errors++;
        end
        strobe_sample(v2);
        pair_errors = test_errors; // Kept apart from the running frame's test.
        test_errors = 0;
        if (in_flight) begin
            complete_frame();
        end
        test_errors = pair_errors;
        wait_busy(1'b1);
        hist.push_back(v2);        // v1 was overwritten before any frame took it.
        wait_frame_done();
        check_plot(h);
        extra = 1'b0;
        for (int i = 0; i < 4 * PLOT_COLS; i++) begin
            next_cycle();
            if (busy || frame_done) begin
                extra = 1'b1;
            end
        end
        assert (!extra) else begin
            $display("FAIL @%0t: a second frame followed the sample pair", $time);
            test_errors++;
        end
        finish_test(name);
    endtask

    function automatic bit load_trace();
        int    fd;
        int    a;
        int    b;
        int    c;
        string line;
        fd = $fopen("verification/plot_trace.txt", "r");
        if (fd == 0) begin
            return 1'b0;
        end
        while ($fgets(line, fd) != 0) begin
            trace_lines++;
            if (line.len() > 2 && line.getc(0) != "#") begin
                a = 0;
                b = 0;
                c = 0;
                void'($sscanf(line.substr(2, line.len() - 1), "%d %d %d", a, b, c));
                cmd_op.push_back(line.getc(0));
                cmd_v1.push_back(a);
                cmd_v2.push_back((line.getc(0) == "B") ? b : 0);
                cmd_h.push_back((line.getc(0) == "B") ? c : b);
            end
        end
        $fclose(fd);
        return cmd_op.size() > 0;
    endfunction

    ////////////////////////////////////////
    // Main sequence.
    ////////////////////////////////////////
    initial begin
        rst_n        = 1'b0;
        sample_valid = 1'b0;
        sample_value = '0;
        if (!load_trace()) begin
            $display("Could not read any command from verification/plot_trace.txt.");
            $display("TESTS FAILED");
            $finish;
        end else begin
            cycle_limit = trace_lines * PLOT_COLS * (PLOT_HEIGHT / 4 + 2) * 10;
            repeat (5) begin
                next_cycle();
                check_idle_ports("during reset");
            end
            rst_n = 1'b1;
            next_cycle();
            check_idle_ports("right after reset");
            assert (busy === 1'b1) else begin
                $display("FAIL @%0t: busy low while init should be running", $time);
                test_errors++;
            end
            finish_test("reset outputs");
            wait_busy(1'b0);   // Init done.
            check_init();
            finish_test("init clear");
            for (int i = 0; i < cmd_op.size(); i++) begin
                if (cmd_op[i] == "B") begin
                    run_pair(cmd_v1[i], cmd_v2[i], cmd_h[i],
                             $sformatf("B %0d %0d", cmd_v1[i], cmd_v2[i]));
                end else if (cmd_op[i] == "S") begin
                    run_single(cmd_v1[i], cmd_h[i], $sformatf("S %0d", cmd_v1[i]));
                end else begin
                    $display("Trace command %0d has an unknown operation.", i);
                    test_errors++;
                    finish_test("trace command");
                end
            end
            if (in_flight) begin
                complete_frame();
            end
            $display("Summary: %0d tests, %0d passed, %0d failed, %0d mismatches",
                     tests_run, tests_run - tests_failed, tests_failed, total_errors);
            if (tests_failed == 0) begin
                $display("TESTS PASSED");
            end else begin
                $display("TESTS FAILED");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- verilog/column_painter.sv
`timescale 1ns/1ps
`default_nettype none

module column_painter
    import plot_map_pkg::*;
    import pixel_pkg::*;
#(
    parameter int                PLOT_COLS   = 16,
    parameter int                PLOT_HEIGHT = 32,
    parameter int                LINE_STRIDE = 64,
    parameter logic [ADDR_W-1:0] PLOT_ORIGIN = 24'h00_0040,
    localparam int               COL_W       = $clog2(PLOT_COLS),
    localparam int               HGT_W       = $clog2(PLOT_HEIGHT + 1)
) (
    input  wire               clk,
    input  wire               rst_n,
    input  wire               paint_start,
    input  wire  [COL_W-1:0]  paint_col,
    input  wire  [HGT_W-1:0]  paint_height,
    input  wire               paint_clear,
    output logic              painter_busy,
    output logic              wr_req,
    output logic [ADDR_W-1:0] wr_addr,
    output logic [BURST_W-1:0] wr_data,
    input  wire               wr_done,
    output logic              paint_done
);

    localparam logic [COL_W-1:0] LAST_COL = COL_W'(PLOT_COLS - 1);
    localparam logic [HGT_W-1:0] LAST_OFS = HGT_W'(PLOT_HEIGHT - BURST_LEN);

    typedef enum logic [1:0] {P_IDLE, P_SEEK, P_WRITE} pstate_t;

    pstate_t           state;
    logic [COL_W-1:0]  acc_col;    // Column that line_base points at.
    logic [ADDR_W-1:0] line_base;  // Pixel 0 of acc_col.
    logic [HGT_W-1:0]  offset;     // First pixel of the current burst.
    logic [COL_W-1:0]  tgt_col;
    logic [HGT_W-1:0]  height;
    logic              clear;

    ////////////////////////////////////////
    // Column walk and burst loop.
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= P_IDLE;
            acc_col    <= '0;
            line_base  <= PLOT_ORIGIN;
            offset     <= '0;
            wr_req     <= 1'b0;
            paint_done <= 1'b0;
        end else begin
            paint_done <= 1'b0;
            case (state)
                P_IDLE: if (paint_start) begin
                    offset <= '0;
                    state  <= P_SEEK;
                end
                // Walk the base forward one stride per cycle, no multiplier.
                P_SEEK: if (acc_col == tgt_col) begin
                    state <= P_WRITE;
                end else if (acc_col == LAST_COL) begin
                    acc_col   <= '0;                   // Wrap to column 0.
                    line_base <= PLOT_ORIGIN;
                end else begin
                    acc_col   <= acc_col + 1'b1;
                    line_base <= line_base + ADDR_W'(LINE_STRIDE);
                end
                P_WRITE: if (wr_done) begin
                    wr_req <= 1'b0;                    // Drop after done.
                    if (offset == LAST_OFS) begin
                        paint_done <= 1'b1;
                        state      <= P_IDLE;
                    end else begin
                        offset <= offset + HGT_W'(BURST_LEN);
                    end
                end else begin
                    wr_req <= 1'b1;
                end
                default: state <= P_IDLE;
            endcase
        end
    end

    // Request is latched as it is accepted.
    always_ff @(posedge clk) begin
        if (paint_start && state == P_IDLE) begin
            tgt_col <= paint_col;
            height  <= paint_height;
            clear   <= paint_clear;
        end
    end

    // Per-word colour, a burst may cross the bar top.
    always_comb begin
        logic [HGT_W-1:0] pix;
        wr_data = '0;
        for (int i = 0; i < BURST_LEN; i++) begin
            pix = offset + HGT_W'(i);
            if (clear) begin
                wr_data[i*WORD_W +: WORD_W] = COLOR_CLEAR;
            end else if (pix < height) begin
                wr_data[i*WORD_W +: WORD_W] = COLOR_BAR;
            end else begin
                wr_data[i*WORD_W +: WORD_W] = COLOR_BACKGROUND;
            end
        end
    end

    assign wr_addr      = line_base + ADDR_W'(offset);
    assign painter_busy = (state != P_IDLE);

endmodule

`default_nettype wire

//--- verilog/pixel_pkg.sv
`default_nettype none

package pixel_pkg;

    ////////////////////////////////////////
    // RGB565 colours of the chart.
    ////////////////////////////////////////

    // Bar body, pink.
    localparam logic [15:0] COLOR_BAR = 16'hF81F;

    // Column space above the bar top, gray.
    localparam logic [15:0] COLOR_BACKGROUND = 16'h8410;

    // Whole plot at power-up, black.
    localparam logic [15:0] COLOR_CLEAR = 16'h0000;

endpackage

`default_nettype wire

//--- verilog/plot_map_pkg.sv
`default_nettype none

package plot_map_pkg;

    ////////////////////////////////////////
    // SDRAM word map.
    ////////////////////////////////////////

    // Bank + row + column word address.
    localparam int ADDR_W = 24;

    // One burst moves four 16-bit words.
    localparam int WORD_W    = 16;
    localparam int BURST_LEN = 4;
    localparam int BURST_W   = BURST_LEN * WORD_W; // Word i at bits 16i and up.

    // Sample ring lives far above any frame area.
    // Each slot holds one sample written four times, so a slot is one burst.
    localparam logic [ADDR_W-1:0] RING_BASE = 24'h10_0000;

endpackage

`default_nettype wire

//--- verilog/plot_renderer_top.sv
`timescale 1ns/1ps
`default_nettype none

module plot_renderer_top
    import plot_map_pkg::*;
#(
    parameter int                PLOT_COLS   = 16,
    parameter int                PLOT_HEIGHT = 32,
    parameter int                LINE_STRIDE = 64,
    parameter logic [ADDR_W-1:0] PLOT_ORIGIN = 24'h00_0040
) (
    input  wire                clk,
    input  wire                rst_n,
    input  wire                sample_valid,
    input  wire  [WORD_W-1:0]  sample_value,
    output logic               rd_req,
    output logic [ADDR_W-1:0]  rd_addr,
    input  wire  [BURST_W-1:0] rd_data,
    input  wire                rd_done,
    output logic               wr_req,
    output logic [ADDR_W-1:0]  wr_addr,
    output logic [BURST_W-1:0] wr_data,
    input  wire                wr_done,
    output logic               busy,
    output logic               frame_done
);

    localparam int COL_W = $clog2(PLOT_COLS);
    localparam int HGT_W = $clog2(PLOT_HEIGHT + 1);

    // Sequencer side of the write port.
    logic               seq_wr_req;
    logic [ADDR_W-1:0]  seq_wr_addr;
    logic [BURST_W-1:0] seq_wr_data;
    // Painter side of the write port.
    logic               pnt_wr_req;
    logic [ADDR_W-1:0]  pnt_wr_addr;
    logic [BURST_W-1:0] pnt_wr_data;

    logic              ring_advance, scan_start, scan_step;
    logic [ADDR_W-1:0] slot_addr;
    logic              paint_start, paint_clear, paint_done, painter_busy;
    logic [COL_W-1:0]  paint_col;
    logic [HGT_W-1:0]  paint_height;

    render_sequencer #(
        .PLOT_COLS   (PLOT_COLS),
        .PLOT_HEIGHT (PLOT_HEIGHT)
    ) u_seq (
        .clk, .rst_n, .sample_valid, .sample_value,
        .rd_req, .rd_addr, .rd_data, .rd_done,
        .seq_wr_req, .seq_wr_addr, .seq_wr_data, .wr_done,
        .ring_advance, .scan_start, .scan_step, .slot_addr,
        .paint_start, .paint_col, .paint_height, .paint_clear,
        .paint_done, .painter_busy, .busy, .frame_done
    );

    ring_index #(.PLOT_COLS(PLOT_COLS)) u_ring (
        .clk, .rst_n, .ring_advance, .scan_start, .scan_step, .slot_addr
    );

    column_painter #(
        .PLOT_COLS   (PLOT_COLS),
        .PLOT_HEIGHT (PLOT_HEIGHT),
        .LINE_STRIDE (LINE_STRIDE),
        .PLOT_ORIGIN (PLOT_ORIGIN)
    ) u_paint (
        .clk, .rst_n, .paint_start, .paint_col, .paint_height, .paint_clear,
        .painter_busy,
        .wr_req  (pnt_wr_req),
        .wr_addr (pnt_wr_addr),
        .wr_data (pnt_wr_data),
        .wr_done,
        .paint_done
    );

    // Painter owns the write port while it runs.
    assign wr_req  = painter_busy ? pnt_wr_req  : seq_wr_req;
    assign wr_addr = painter_busy ? pnt_wr_addr : seq_wr_addr;
    assign wr_data = painter_busy ? pnt_wr_data : seq_wr_data;

endmodule

`default_nettype wire

//--- verilog/render_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module render_sequencer
    import plot_map_pkg::*;
#(
    parameter int  PLOT_COLS   = 16,
    parameter int  PLOT_HEIGHT = 32,
    localparam int COL_W       = $clog2(PLOT_COLS),
    localparam int HGT_W       = $clog2(PLOT_HEIGHT + 1)
) (
    input  wire                clk,
    input  wire                rst_n,
    input  wire                sample_valid,
    input  wire  [WORD_W-1:0]  sample_value,
    output logic               rd_req,
    output logic [ADDR_W-1:0]  rd_addr,
    input  wire  [BURST_W-1:0] rd_data,
    input  wire                rd_done,
    output logic               seq_wr_req,
    output logic [ADDR_W-1:0]  seq_wr_addr,
    output logic [BURST_W-1:0] seq_wr_data,
    input  wire                wr_done,
    output logic               ring_advance,
    output logic               scan_start,
    output logic               scan_step,
    input  wire  [ADDR_W-1:0]  slot_addr,
    output logic               paint_start,
    output logic [COL_W-1:0]   paint_col,
    output logic [HGT_W-1:0]   paint_height,
    output logic               paint_clear,
    input  wire                paint_done,
    input  wire                painter_busy,
    output logic               busy,
    output logic               frame_done
);

    localparam logic [COL_W-1:0]  LAST_COL = COL_W'(PLOT_COLS - 1);
    localparam logic [WORD_W-1:0] HGT_MAX  = WORD_W'(PLOT_HEIGHT);

    typedef enum logic [2:0] {S_LOAD, S_WR, S_RD, S_PAINT, S_WAIT, S_IDLE} state_t;

    state_t            state;
    logic              clearing;   // Init pass, ring zero then plot clear.
    logic [COL_W-1:0]  col;
    logic              pending;
    logic [WORD_W-1:0] pend_value; // Latest strobe wins.
    logic [WORD_W-1:0] cur_sample; // Sample of the running frame.

    ////////////////////////////////////////
    // Main FSM.
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= S_LOAD;                  // Init starts at once.
            clearing   <= 1'b1;
            col        <= '0;
            pending    <= 1'b0;
            rd_req     <= 1'b0;
            seq_wr_req <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            // New strobe beats the take, so it waits for the next frame.
            if (sample_valid) begin
                pending <= 1'b1;
            end else if (state == S_IDLE) begin
                pending <= 1'b0;
            end
            case (state)
                S_IDLE: if (pending) state <= S_LOAD;
                S_LOAD: state <= S_WR;             // Scan slot = head.
                // Ring slot write, zero at init or the new sample.
                S_WR: if (wr_done) begin
                    seq_wr_req <= 1'b0;
                    if (!clearing) begin
                        state <= S_RD;             // Head moved, scan at oldest.
                    end else if (col == LAST_COL) begin
                        col   <= '0;
                        state <= S_PAINT;
                    end else begin
                        col <= col + 1'b1;
                    end
                end else begin
                    seq_wr_req <= 1'b1;
                end
                S_RD: if (rd_done) begin
                    rd_req <= 1'b0;
                    state  <= S_PAINT;
                end else begin
                    rd_req <= 1'b1;
                end
                S_PAINT: if (!painter_busy) state <= S_WAIT;
                S_WAIT: if (paint_done) begin
                    if (col == LAST_COL) begin
                        col        <= '0;
                        frame_done <= !clearing;   // No pulse for init.
                        clearing   <= 1'b0;
                        state      <= S_IDLE;
                    end else begin
                        col   <= col + 1'b1;
                        state <= clearing ? S_PAINT : S_RD;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Sample capture and height clip.
    always_ff @(posedge clk) begin
        if (sample_valid) begin
            pend_value <= sample_value;
        end
        if (state == S_IDLE && pending) begin
            cur_sample <= pend_value;
        end
        if (state == S_RD && rd_done) begin
            if (rd_data[WORD_W-1:0] > HGT_MAX) begin
                paint_height <= HGT_W'(PLOT_HEIGHT); // Full bar.
            end else begin
                paint_height <= rd_data[HGT_W-1:0];
            end
        end
    end

    ////////////////////////////////////////
    // Strobes and port values.
    ////////////////////////////////////////
    assign scan_start   = (state == S_LOAD);
    assign scan_step    = (state == S_WR && wr_done) || (state == S_RD && rd_done);
    assign ring_advance = (state == S_WR) && wr_done && !clearing;
    assign paint_start  = (state == S_PAINT) && !painter_busy;
    assign paint_col    = col;
    assign paint_clear  = clearing;

    // Slot address holds still until done, so both ports use it directly.
    assign rd_addr     = slot_addr;
    assign seq_wr_addr = slot_addr;
    assign seq_wr_data = clearing ? '0 : {BURST_LEN{cur_sample}}; // Four copies.

    assign busy = (state != S_IDLE);

endmodule

`default_nettype wire

//--- verilog/ring_index.sv
`timescale 1ns/1ps
`default_nettype none

module ring_index
    import plot_map_pkg::*;
#(
    parameter int PLOT_COLS = 16
) (
    input  wire              clk,
    input  wire              rst_n,
    input  wire              ring_advance,
    input  wire              scan_start,
    input  wire              scan_step,
    output logic [ADDR_W-1:0] slot_addr
);

    // Address of the last slot, one burst below the wrap point.
    localparam logic [ADDR_W-1:0] LAST_SLOT =
        RING_BASE + ADDR_W'(BURST_LEN * (PLOT_COLS - 1));

    logic [ADDR_W-1:0] head_addr; // Slot for the next sample.
    logic [ADDR_W-1:0] scan_addr; // Slot being walked.

    // Step one slot forward, wrapping to the ring base.
    function automatic logic [ADDR_W-1:0] next_slot(input logic [ADDR_W-1:0] addr);
        logic [ADDR_W-1:0] nxt;
        if (addr == LAST_SLOT) begin
            nxt = RING_BASE;
        end else begin
            nxt = addr + ADDR_W'(BURST_LEN); // Slots are one burst apart.
        end
        return nxt;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head_addr <= RING_BASE;
            scan_addr <= RING_BASE;
        end else begin
            if (ring_advance) begin
                head_addr <= next_slot(head_addr);
            end
            // Scan restarts at the head, then walks oldest first.
            if (scan_start) begin
                scan_addr <= head_addr;
            end else if (scan_step) begin
                scan_addr <= next_slot(scan_addr);
            end
        end
    end

    // Writes and reads both go to the scan slot.
    assign slot_addr = scan_addr;

endmodule

`default_nettype wire

//--- vlog.f
verilog/plot_map_pkg.sv
verilog/pixel_pkg.sv
verilog/ring_index.sv
verilog/column_painter.sv
verilog/render_sequencer.sv
verilog/plot_renderer_top.sv
verification/sdram_burst_model.sv
verification/tb_plot_renderer.sv
